/* build.f */
+incdir+design
design/acq_pkg.sv
design/acq_ifs.sv
design/grid_sequencer.sv
design/power_detector.sv
design/peak_search.sv
design/acq_engine.sv
verif/acq_engine_asserts.sv
verif/acq_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the acquisition engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module acq_engine_tb -Mdir obj_dir

./obj_dir/Vacq_engine_tb | tee "$LOG"

if grep -q "^Test OK$" "$LOG"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* verif/acq_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module acq_engine_tb;
   import acq_pkg::*;

   localparam int NUM_ROWS = 6;
   localparam int SHIFTS   = `ACQ_MAX_CODE_SHIFT + 1;
   localparam int NUM_BINS = SHIFTS * `ACQ_DOPP_BINS;
   localparam int TIMEOUT  = 500;

   // one search with the planted peak and the handshake delays
   typedef struct {
      string    name;
      int       bin;
      tap_sel_e tap;
      int       i_val;
      int       q_val;
      bit       tie;
      int       req_delay;
      int       ack_delay;
   } test_row_t;

   logic        clk;
   logic        rst_n;
   logic        acq_mode;
   logic        corr_req;
   logic        corr_ack;
   iq_t         corr_i_early;
   iq_t         corr_q_early;
   iq_t         corr_i_prompt;
   iq_t         corr_q_prompt;
   iq_t         corr_i_late;
   iq_t         corr_q_late;
   code_shift_t code_shift;
   doppler_t    doppler_early;
   doppler_t    doppler_prompt;
   doppler_t    doppler_late;
   logic        result_req;
   logic        result_ack;
   power_t      peak_power;
   doppler_t    peak_doppler;
   code_shift_t peak_code_shift;

   test_row_t   rows [NUM_ROWS];
   iq_t         sums [6];
   logic [31:0] lcg_state;
   int          error_count;
   int          timeout_count;

   acq_engine u_acq_engine (
      .clk             (clk),
      .rst_n           (rst_n),
      .acq_mode        (acq_mode),
      .corr_req        (corr_req),
      .corr_ack        (corr_ack),
      .corr_i_early    (corr_i_early),
      .corr_q_early    (corr_q_early),
      .corr_i_prompt   (corr_i_prompt),
      .corr_q_prompt   (corr_q_prompt),
      .corr_i_late     (corr_i_late),
      .corr_q_late     (corr_q_late),
      .code_shift      (code_shift),
      .doppler_early   (doppler_early),
      .doppler_prompt  (doppler_prompt),
      .doppler_late    (doppler_late),
      .result_req      (result_req),
      .result_ack      (result_ack),
      .peak_power      (peak_power),
      .peak_doppler    (peak_doppler),
      .peak_code_shift (peak_code_shift)
   );

   always #50 clk = ~clk;

   task automatic load_rows();
      rows[0] = '{"first_bin_early", 0, TAP_EARLY, 1500, -900, 1'b0, 0, 0};
      rows[1] = '{"mid_bin_prompt", 11, TAP_PROMPT, -700, 600, 1'b0, 3, 2};
      rows[2] = '{"last_bin_late", 23, TAP_LATE, 400, 450, 1'b0, 0, 5};
      rows[3] = '{"tie_between_taps", 5, TAP_EARLY, 800, 800, 1'b1, 2, 0};
      rows[4] = '{"tie_between_bins", 15, TAP_LATE, -1000, 300, 1'b1, 4, 3};
      rows[5] = '{"smaller_peak_after", 9, TAP_PROMPT, 200, -150, 1'b0, 1, 1};
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // background sum in -63..63
   function automatic iq_t background_sum();
      logic [31:0] r;
      r = lcg_next();
      return iq_t'(int'(r[23:16] % 8'd127) - 63);
   endfunction

   function automatic power_t expected_power(int i_val, int q_val);
      return power_t'(i_val * i_val + q_val * q_val);
   endfunction

   function automatic doppler_t expected_doppler(int bin, tap_sel_e tap);
      int d;
      d = `ACQ_DOPP_PROMPT_START + `ACQ_DOPP_STEP * (bin / SHIFTS);
      if (tap == TAP_EARLY)
         d = d + `ACQ_DOPP_SPACING;
      else if (tap == TAP_LATE)
         d = d - `ACQ_DOPP_SPACING;
      return doppler_t'(d);
   endfunction

   task automatic check_power(string name, power_t expected, power_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_doppler(string name, doppler_t expected, doppler_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_code_shift(string name, code_shift_t expected, code_shift_t actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_bit(string name, logic expected, logic actual);
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   endtask

   task automatic report_timeout(string what);
      timeout_count++;
      $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_corr_ack(logic level);
      int n;
      n = 0;
      while (corr_ack !== level && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (corr_ack !== level)
         report_timeout(level ? "corr_ack to rise" : "corr_ack to fall");
   endtask

   task automatic wait_result_req(logic level);
      int n;
      n = 0;
      while (result_req !== level && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (result_req !== level)
         report_timeout(level ? "result_req to rise" : "result_req to fall");
   endtask

   task automatic plant(tap_sel_e tap, int i_val, int q_val);
      sums[2 * int'(tap)]     = iq_t'(i_val);
      sums[2 * int'(tap) + 1] = iq_t'(q_val);
   endtask

   // correlator model puts noise everywhere and the planted value where the row says
   task automatic drive_sums(test_row_t row, int bin);
      int       tie_bin;
      tap_sel_e tie_tap;
      for (int k = 0; k < 6; k++)
         sums[k] = background_sum();
      if (row.tap == TAP_LATE) begin
         tie_bin = row.bin + 1;
         tie_tap = TAP_EARLY;
      end else begin
         tie_bin = row.bin;
         tie_tap = tap_sel_e'(int'(row.tap) + 1);
      end
      if (bin == row.bin)
         plant(row.tap, row.i_val, row.q_val);
      if (row.tie && bin == tie_bin)
         plant(tie_tap, row.i_val, row.q_val);
      corr_i_early  = sums[0];
      corr_q_early  = sums[1];
      corr_i_prompt = sums[2];
      corr_q_prompt = sums[3];
      corr_i_late   = sums[4];
      corr_q_late   = sums[5];
   endtask

   task automatic answer_bin(test_row_t row, int bin);
      int delay;
      delay = int'(lcg_next() % (row.req_delay + 1));
      repeat (delay) next_cycle();
      check_code_shift($sformatf("%s bin %0d code_shift", row.name, bin),
                       code_shift_t'(bin % SHIFTS), code_shift);
      check_doppler($sformatf("%s bin %0d doppler_early", row.name, bin),
                    expected_doppler(bin, TAP_EARLY), doppler_early);
      check_doppler($sformatf("%s bin %0d doppler_prompt", row.name, bin),
                    expected_doppler(bin, TAP_PROMPT), doppler_prompt);
      check_doppler($sformatf("%s bin %0d doppler_late", row.name, bin),
                    expected_doppler(bin, TAP_LATE), doppler_late);
      drive_sums(row, bin);
      corr_req = 1'b1;
      wait_corr_ack(1'b1);
      corr_req = 1'b0;
      if (timeout_count == 0)
         wait_corr_ack(1'b0);
   endtask

   task automatic check_result(test_row_t row, string what);
      check_power($sformatf("%s %s power", row.name, what),
                  expected_power(row.i_val, row.q_val), peak_power);
      check_doppler($sformatf("%s %s doppler", row.name, what),
                    expected_doppler(row.bin, row.tap), peak_doppler);
      check_code_shift($sformatf("%s %s code_shift", row.name, what),
                       code_shift_t'(row.bin % SHIFTS), peak_code_shift);
   endtask

   task automatic run_row(test_row_t row);
      next_cycle();
      acq_mode = 1'b1;
      next_cycle();
      acq_mode = 1'b0;
      for (int bin = 0; bin < NUM_BINS && timeout_count == 0; bin++)
         answer_bin(row, bin);
      if (timeout_count != 0)
         return;
      wait_result_req(1'b1);
      if (timeout_count != 0)
         return;
      check_result(row, "result");
      // result must hold while the ack is late
      repeat (row.ack_delay) begin
         next_cycle();
         check_bit({row.name, " result_req held"}, 1'b1, result_req);
         check_result(row, "held result");
      end
      result_ack = 1'b1;
      wait_result_req(1'b0);
      result_ack = 1'b0;
      next_cycle();
   endtask

   initial begin
      int r;
      clk           = 1'b0;
      rst_n         = 1'b0;
      acq_mode      = 1'b0;
      corr_req      = 1'b0;
      result_ack    = 1'b0;
      corr_i_early  = '0;
      corr_q_early  = '0;
      corr_i_prompt = '0;
      corr_q_prompt = '0;
      corr_i_late   = '0;
      corr_q_late   = '0;
      lcg_state     = 32'd56;
      error_count   = 0;
      timeout_count = 0;
      load_rows();
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      check_bit("reset corr_ack", 1'b0, corr_ack);
      check_bit("reset result_req", 1'b0, result_req);
      check_code_shift("reset code_shift", '0, code_shift);
      check_doppler("reset doppler_early", '0, doppler_early);
      check_doppler("reset doppler_prompt", '0, doppler_prompt);
      check_doppler("reset doppler_late", '0, doppler_late);
      check_power("reset peak_power", '0, peak_power);
      for (r = 0; r < NUM_ROWS && timeout_count == 0; r++)
         run_row(rows[r]);
      finish_run();
   end

endmodule

`default_nettype wire

/* verif/acq_engine_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module acq_engine_asserts (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 corr_req,
   input logic                 corr_ack,
   input logic                 result_req,
   input logic                 result_ack,
   input acq_pkg::code_shift_t code_shift,
   input logic                 iq_valid,
   input logic                 iq_ready,
   input logic                 pwr_valid,
   input logic                 pwr_ready
);
   import acq_pkg::*;

   // ack only rises for a request seen on the capturing edge
   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(corr_ack) |-> $past(corr_req))
      else $error("corr_ack rose without corr_req");

   result_held: assert property (@(posedge clk) disable iff (!rst_n)
      result_req && !result_ack |=> result_req)
      else $error("result_req dropped before result_ack");

   shift_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      code_shift <= code_shift_t'(`ACQ_MAX_CODE_SHIFT))
      else $error("code_shift beyond the last searched shift");

   iq_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
      iq_valid && !iq_ready |=> iq_valid)
      else $error("iq bin valid dropped without ready");

   pwr_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
      pwr_valid && !pwr_ready |=> pwr_valid)
      else $error("power bin valid dropped without ready");

endmodule

bind acq_engine acq_engine_asserts u_acq_engine_asserts (
   .clk        (clk),
   .rst_n      (rst_n),
   .corr_req   (corr_req),
   .corr_ack   (corr_ack),
   .result_req (result_req),
   .result_ack (result_ack),
   .code_shift (code_shift),
   .iq_valid   (iq_bin.valid),
   .iq_ready   (iq_bin.ready),
   .pwr_valid  (pwr_bin.valid),
   .pwr_ready  (pwr_bin.ready)
);

`default_nettype wire

/* design/acq_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_engine (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 acq_mode,
   input  logic                 corr_req,
   output logic                 corr_ack,
   input  acq_pkg::iq_t         corr_i_early,
   input  acq_pkg::iq_t         corr_q_early,
   input  acq_pkg::iq_t         corr_i_prompt,
   input  acq_pkg::iq_t         corr_q_prompt,
   input  acq_pkg::iq_t         corr_i_late,
   input  acq_pkg::iq_t         corr_q_late,
   output acq_pkg::code_shift_t code_shift,
   output acq_pkg::doppler_t    doppler_early,
   output acq_pkg::doppler_t    doppler_prompt,
   output acq_pkg::doppler_t    doppler_late,
   output logic                 result_req,
   input  logic                 result_ack,
   output acq_pkg::power_t      peak_power,
   output acq_pkg::doppler_t    peak_doppler,
   output acq_pkg::code_shift_t peak_code_shift
);

   iq_bin_if  iq_bin ();
   pwr_bin_if pwr_bin ();

   grid_sequencer u_grid_sequencer (
      .clk            (clk),
      .rst_n          (rst_n),
      .acq_mode       (acq_mode),
      .corr_req       (corr_req),
      .corr_ack       (corr_ack),
      .corr_i_early   (corr_i_early),
      .corr_q_early   (corr_q_early),
      .corr_i_prompt  (corr_i_prompt),
      .corr_q_prompt  (corr_q_prompt),
      .corr_i_late    (corr_i_late),
      .corr_q_late    (corr_q_late),
      .code_shift     (code_shift),
      .doppler_early  (doppler_early),
      .doppler_prompt (doppler_prompt),
      .doppler_late   (doppler_late),
      .bin            (iq_bin.src)
   );

   power_detector u_power_detector (
      .clk     (clk),
      .rst_n   (rst_n),
      .bin_in  (iq_bin.dst),
      .bin_out (pwr_bin.src)
   );

   peak_search u_peak_search (
      .clk             (clk),
      .rst_n           (rst_n),
      .bin_in          (pwr_bin.dst),
      .result_req      (result_req),
      .result_ack      (result_ack),
      .peak_power      (peak_power),
      .peak_doppler    (peak_doppler),
      .peak_code_shift (peak_code_shift)
   );

endmodule

`default_nettype wire

/* design/peak_search.sv */
`timescale 1ns/1ps
`default_nettype none

module peak_search (
   input  logic                 clk,
   input  logic                 rst_n,
   pwr_bin_if.dst               bin_in,
   output logic                 result_req,
   input  logic                 result_ack,
   output acq_pkg::power_t      peak_power,
   output acq_pkg::doppler_t    peak_doppler,
   output acq_pkg::code_shift_t peak_code_shift
);
   import acq_pkg::*;

   peak_state_e state;
   tap_sel_e    tap;
   logic        greater;
   bin_tag_t    cur_tag;
   power_t      cur_early;
   power_t      cur_prompt;
   power_t      cur_late;
   power_t      next_power;
   doppler_t    next_doppler;

   // a bin is taken only while idle
   assign bin_in.ready = (state == PK_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state           <= PK_IDLE;
         tap             <= TAP_EARLY;
         result_req      <= 1'b0;
         peak_power      <= '0;
         peak_doppler    <= '0;
         peak_code_shift <= '0;
      end else begin
         case (state)
            PK_IDLE: begin
               if (bin_in.valid) begin
                  tap   <= TAP_EARLY;
                  state <= PK_SELECT;
                  // first bin of a search starts from a zero peak
                  if (bin_in.tag.first) begin
                     peak_power      <= '0;
                     peak_doppler    <= '0;
                     peak_code_shift <= '0;
                  end
               end
            end
            PK_SELECT:  state <= PK_COMPARE;
            PK_COMPARE: state <= PK_UPDATE;
            PK_UPDATE: begin
               // ties keep the earlier tap or bin
               if (greater) begin
                  peak_power      <= next_power;
                  peak_doppler    <= next_doppler;
                  peak_code_shift <= cur_tag.code_shift;
               end
               if (tap == TAP_LATE) begin
                  if (cur_tag.last) begin
                     result_req <= 1'b1;
                     state      <= PK_REPORT;
                  end else begin
                     state <= PK_IDLE;
                  end
               end else begin
                  tap   <= (tap == TAP_EARLY) ? TAP_PROMPT : TAP_LATE;
                  state <= PK_SELECT;
               end
            end
            PK_REPORT: begin
               if (result_ack) begin
                  result_req <= 1'b0;
                  state      <= PK_WAIT_DROP;
               end
            end
            PK_WAIT_DROP: begin
               if (!result_ack)
                  state <= PK_IDLE;
            end
            default: state <= PK_IDLE;
         endcase
      end
   end

   // latched bin plus the select and compare steps
   always_ff @(posedge clk) begin
      if (state == PK_IDLE && bin_in.valid) begin
         cur_tag    <= bin_in.tag;
         cur_early  <= bin_in.power_early;
         cur_prompt <= bin_in.power_prompt;
         cur_late   <= bin_in.power_late;
      end
      if (state == PK_SELECT) begin
         case (tap)
            TAP_EARLY: begin
               next_power   <= cur_early;
               next_doppler <= cur_tag.doppler_early;
            end
            TAP_PROMPT: begin
               next_power   <= cur_prompt;
               next_doppler <= cur_tag.doppler_prompt;
            end
            default: begin
               next_power   <= cur_late;
               next_doppler <= cur_tag.doppler_late;
            end
         endcase
      end
      if (state == PK_COMPARE)
         greater <= (next_power > peak_power);
   end

endmodule

`default_nettype wire

/* design/power_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module power_detector (
   input  logic  clk,
   input  logic  rst_n,
   iq_bin_if.dst bin_in,
   pwr_bin_if.src bin_out
);
   import acq_pkg::*;

   logic     advance;
   logic     s1_valid;
   bin_tag_t s1_tag;
   power_t   s1_ie;
   power_t   s1_qe;
   power_t   s1_ip;
   power_t   s1_qp;
   power_t   s1_il;
   power_t   s1_ql;

   // square of a signed sum is never negative
   function automatic power_t square(iq_t x);
      logic signed [$bits(power_t)-1:0] xs;
      logic signed [$bits(power_t)-1:0] p;
      xs = x;
      p  = xs * xs;
      return power_t'(p);
   endfunction

   // whole pipeline moves together and freezes while the output is stuck
   assign advance      = !bin_out.valid || bin_out.ready;
   assign bin_in.ready = advance;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid      <= 1'b0;
         bin_out.valid <= 1'b0;
      end else if (advance) begin
         s1_valid      <= bin_in.valid;
         bin_out.valid <= s1_valid;
      end
   end

   // stage one registers six squares
   always_ff @(posedge clk) begin
      if (advance && bin_in.valid) begin
         s1_tag <= bin_in.tag;
         s1_ie  <= square(bin_in.i_early);
         s1_qe  <= square(bin_in.q_early);
         s1_ip  <= square(bin_in.i_prompt);
         s1_qp  <= square(bin_in.q_prompt);
         s1_il  <= square(bin_in.i_late);
         s1_ql  <= square(bin_in.q_late);
      end
   end

   // stage two forms I^2 + Q^2 per tap
   always_ff @(posedge clk) begin
      if (advance && s1_valid) begin
         bin_out.tag          <= s1_tag;
         bin_out.power_early  <= s1_ie + s1_qe;
         bin_out.power_prompt <= s1_ip + s1_qp;
         bin_out.power_late   <= s1_il + s1_ql;
      end
   end

endmodule

`default_nettype wire

/* design/grid_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module grid_sequencer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 acq_mode,
   input  logic                 corr_req,
   output logic                 corr_ack,
   input  acq_pkg::iq_t         corr_i_early,
   input  acq_pkg::iq_t         corr_q_early,
   input  acq_pkg::iq_t         corr_i_prompt,
   input  acq_pkg::iq_t         corr_q_prompt,
   input  acq_pkg::iq_t         corr_i_late,
   input  acq_pkg::iq_t         corr_q_late,
   output acq_pkg::code_shift_t code_shift,
   output acq_pkg::doppler_t    doppler_early,
   output acq_pkg::doppler_t    doppler_prompt,
   output acq_pkg::doppler_t    doppler_late,
   iq_bin_if.src                bin
);
   import acq_pkg::*;

   localparam int unsigned STEP_W = $clog2(`ACQ_DOPP_BINS + 1);

   seq_state_e        state;
   logic              acq_mode_q;
   logic              start;
   logic              capture;
   logic              wrap;
   logic              last_bin;
   logic              grid_done;
   logic [STEP_W-1:0] dopp_step;

   // rising level on acq_mode starts or restarts the search
   assign start = acq_mode & ~acq_mode_q;

   assign wrap     = (code_shift == code_shift_t'(`ACQ_MAX_CODE_SHIFT));
   assign last_bin = wrap && (dopp_step == STEP_W'(`ACQ_DOPP_BINS - 1));

   // output register must be free (or draining this edge) to take new sums
   assign capture = (state == SEQ_WAIT_REQ) && corr_req && !start &&
                    (!bin.valid || bin.ready);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= SEQ_IDLE;
         acq_mode_q <= 1'b0;
         corr_ack   <= 1'b0;
         grid_done  <= 1'b0;
      end else begin
         acq_mode_q <= acq_mode;
         if (start)
            grid_done <= 1'b0;
         else if (capture && last_bin)
            grid_done <= 1'b1;
         case (state)
            SEQ_IDLE, SEQ_DONE: begin
               if (start)
                  state <= SEQ_WAIT_REQ;
            end
            SEQ_WAIT_REQ: begin
               if (capture) begin
                  corr_ack <= 1'b1;
                  state    <= SEQ_WAIT_DROP;
               end
            end
            SEQ_WAIT_DROP: begin
               // a restart here still lets the current exchange finish
               if (!corr_req) begin
                  corr_ack <= 1'b0;
                  state    <= (grid_done && !start) ? SEQ_DONE : SEQ_WAIT_REQ;
               end
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // published grid point advances on every capture
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         code_shift     <= '0;
         doppler_early  <= '0;
         doppler_prompt <= '0;
         doppler_late   <= '0;
         dopp_step      <= '0;
      end else if (start) begin
         code_shift     <= '0;
         dopp_step      <= '0;
         doppler_prompt <= doppler_t'(`ACQ_DOPP_PROMPT_START);
         doppler_early  <= doppler_t'(`ACQ_DOPP_PROMPT_START + `ACQ_DOPP_SPACING);
         doppler_late   <= doppler_t'(`ACQ_DOPP_PROMPT_START - `ACQ_DOPP_SPACING);
      end else if (capture) begin
         if (wrap) begin
            code_shift     <= '0;
            dopp_step      <= dopp_step + 1'b1;
            doppler_early  <= doppler_early + doppler_t'(`ACQ_DOPP_STEP);
            doppler_prompt <= doppler_prompt + doppler_t'(`ACQ_DOPP_STEP);
            doppler_late   <= doppler_late + doppler_t'(`ACQ_DOPP_STEP);
         end else begin
            code_shift <= code_shift + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         bin.valid <= 1'b0;
      else if (capture)
         bin.valid <= 1'b1;
      else if (bin.ready)
         bin.valid <= 1'b0;
   end

   // sums and their grid point
   always_ff @(posedge clk) begin
      if (capture) begin
         bin.i_early             <= corr_i_early;
         bin.q_early             <= corr_q_early;
         bin.i_prompt            <= corr_i_prompt;
         bin.q_prompt            <= corr_q_prompt;
         bin.i_late              <= corr_i_late;
         bin.q_late              <= corr_q_late;
         bin.tag.code_shift      <= code_shift;
         bin.tag.doppler_early   <= doppler_early;
         bin.tag.doppler_prompt  <= doppler_prompt;
         bin.tag.doppler_late    <= doppler_late;
         bin.tag.first           <= (code_shift == '0) && (dopp_step == '0);
         bin.tag.last            <= last_bin;
      end
   end

endmodule

`default_nettype wire

/* design/acq_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// correlation sums of one grid point, sequencer to power pipeline
interface iq_bin_if;
   import acq_pkg::*;

   logic     valid;
   logic     ready;
   bin_tag_t tag;
   iq_t      i_early;
   iq_t      q_early;
   iq_t      i_prompt;
   iq_t      q_prompt;
   iq_t      i_late;
   iq_t      q_late;

   modport src (output valid, output tag, output i_early, output q_early,
                output i_prompt, output q_prompt, output i_late, output q_late,
                input ready);
   modport dst (input valid, input tag, input i_early, input q_early,
                input i_prompt, input q_prompt, input i_late, input q_late,
                output ready);
endinterface

// tap powers of one grid point, power pipeline to peak search
interface pwr_bin_if;
   import acq_pkg::*;

   logic     valid;
   logic     ready;
   bin_tag_t tag;
   power_t   power_early;
   power_t   power_prompt;
   power_t   power_late;

   modport src (output valid, output tag, output power_early, output power_prompt,
                output power_late, input ready);
   modport dst (input valid, input tag, input power_early, input power_prompt,
                input power_late, output ready);
endinterface

`default_nettype wire

/* design/acq_pkg.sv */
`default_nettype none

`include "acq_cfg.svh"

package acq_pkg;

   typedef logic signed [`ACQ_IQ_WIDTH-1:0]   iq_t;
   typedef logic        [`ACQ_POWER_WIDTH-1:0] power_t;
   typedef logic        [`ACQ_CS_WIDTH-1:0]    code_shift_t;
   typedef logic signed [`ACQ_DOPP_WIDTH-1:0] doppler_t;

   // grid point that travels alongside its data
   typedef struct packed {
      code_shift_t code_shift;
      doppler_t    doppler_early;
      doppler_t    doppler_prompt;
      doppler_t    doppler_late;
      logic        first;
      logic        last;
   } bin_tag_t;

   typedef enum logic [1:0] {
      SEQ_IDLE, SEQ_WAIT_REQ, SEQ_WAIT_DROP, SEQ_DONE
   } seq_state_e;

   typedef enum logic [2:0] {
      PK_IDLE, PK_SELECT, PK_COMPARE, PK_UPDATE, PK_REPORT, PK_WAIT_DROP
   } peak_state_e;

   typedef enum logic [1:0] {
      TAP_EARLY, TAP_PROMPT, TAP_LATE
   } tap_sel_e;

endpackage

`default_nettype wire

/* design/acq_cfg.svh */
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// signed correlation sum from the correlator
`define ACQ_IQ_WIDTH 12

// I^2 + Q^2, wide enough for two full-scale squares
`define ACQ_POWER_WIDTH 24

// code shift search range
`define ACQ_CS_WIDTH 4
`define ACQ_MAX_CODE_SHIFT 7

// doppler increment word
`define ACQ_DOPP_WIDTH 16

// number of doppler steps in one search
`define ACQ_DOPP_BINS 3

// first prompt doppler of the grid
`define ACQ_DOPP_PROMPT_START (-300)

// early sits above prompt, late below, by this much
`define ACQ_DOPP_SPACING 100

// prompt increment after each full code shift sweep
`define ACQ_DOPP_STEP 300

`endif
